// ==== hw/lq_pkg.sv ====
// shared load queue types; the size codes follow the RISC-V load funct3 with code 6 reused for fp16 NaN-boxing
package lq_pkg;

  // one load or execute result
  typedef logic [31:0] word_t;

  // access size code
  // bit 2 marks unsigned except in the NaN-box code, low bits pick byte, half or word
  typedef logic [2:0] ld_size_t;

  // byte offset of the access within the word
  typedef logic [1:0] byte_off_t;

  // destination register number
  typedef logic [4:0] reg_addr_t;

  localparam ld_size_t SZ_B    = 3'd0;  // signed byte
  localparam ld_size_t SZ_H    = 3'd1;  // signed half
  localparam ld_size_t SZ_W    = 3'd2;  // full word
  localparam ld_size_t SZ_BU   = 3'd4;  // unsigned byte
  localparam ld_size_t SZ_HU   = 3'd5;  // unsigned half
  localparam ld_size_t SZ_HNAN = 3'd6;  // half with upper 16 bits forced to ones

endpackage

// ==== hw/lq_store_if.sv ====
// per-port fields are indexed by memory return port; the head fields always follow the read pointer
interface lq_store_if import lq_pkg::*; #(
  parameter int LQ_DEPTH      = 8,
  parameter int NUM_RET_PORTS = 2
);

  localparam int ID_W = $clog2(LQ_DEPTH);

  // metadata lookup for each return port
  logic      [NUM_RET_PORTS-1:0][ID_W-1:0] lookup_id;
  ld_size_t  [NUM_RET_PORTS-1:0]           lookup_size;
  byte_off_t [NUM_RET_PORTS-1:0]           lookup_offset;

  // aligned load results written into the entries
  logic      [NUM_RET_PORTS-1:0]           wr_en;
  logic      [NUM_RET_PORTS-1:0][ID_W-1:0] wr_id;
  word_t     [NUM_RET_PORTS-1:0]           wr_data;

  // oldest entry
  logic      [ID_W-1:0]                    head_id;
  ld_size_t                                head_size;
  byte_off_t                               head_offset;
  word_t                                   head_data;
  logic                                    head_data_vld;
  logic                                    head_is_load;

  modport store (
    input  lookup_id, wr_en, wr_id, wr_data,
    output lookup_size, lookup_offset,
    output head_id, head_size, head_offset, head_data, head_data_vld, head_is_load
  );

  modport ret (
    output lookup_id, wr_en, wr_id, wr_data,
    input  lookup_size, lookup_offset,
    input  head_id, head_size, head_offset, head_data, head_data_vld, head_is_load
  );

endinterface

// ==== hw/lq_pointers.sv ====
// LQ_DEPTH must be a power of two; allocating while full or dequeuing while empty is illegal
module lq_pointers #(
  parameter int LQ_DEPTH = 8
) (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  logic                        i_alloc,
  input  logic                        i_rden,
  output logic [$clog2(LQ_DEPTH)-1:0] o_wr_idx,
  output logic [$clog2(LQ_DEPTH)-1:0] o_rd_idx,
  output logic                        o_full,
  output logic                        o_empty
);

  localparam int ID_W = $clog2(LQ_DEPTH);

  logic [ID_W:0] wr_ptr;  // msb is the wrap bit
  logic [ID_W:0] rd_ptr;
  logic          idx_equal;

  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (i_alloc) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_rden) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  assign idx_equal = (wr_ptr[ID_W-1:0] == rd_ptr[ID_W-1:0]);

  // same index, wrap bits tell full from empty
  assign o_full  = idx_equal && (wr_ptr[ID_W] != rd_ptr[ID_W]);
  assign o_empty = idx_equal && (wr_ptr[ID_W] == rd_ptr[ID_W]);

  assign o_wr_idx = wr_ptr[ID_W-1:0];
  assign o_rd_idx = rd_ptr[ID_W-1:0];

  a_no_alloc_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_alloc |-> !o_full)
    else $error("allocation while the load queue is full");

  a_no_rden_empty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_rden |-> !o_empty)
    else $error("dequeue while the load queue is empty");

endmodule

// ==== hw/lq_entry_store.sv ====
// payload fields have no reset and read X until written; every writer must target an allocated entry
module lq_entry_store import lq_pkg::*; #(
  parameter int LQ_DEPTH      = 8,
  parameter int NUM_RET_PORTS = 2
) (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  // allocation at decode
  input  logic                        i_alloc,
  input  logic [$clog2(LQ_DEPTH)-1:0] i_wr_idx,
  input  logic                        i_alloc_load,
  input  reg_addr_t                   i_alloc_rd,
  // retire from the head
  input  logic                        i_rden,
  input  logic [$clog2(LQ_DEPTH)-1:0] i_rd_idx,
  // address stage metadata
  input  logic                        i_meta_vld,
  input  logic [$clog2(LQ_DEPTH)-1:0] i_meta_id,
  input  ld_size_t                    i_meta_size,
  input  byte_off_t                   i_meta_offset,
  // non-load result from execute
  input  logic                        i_ex_vld,
  input  logic [$clog2(LQ_DEPTH)-1:0] i_ex_id,
  input  word_t                       i_ex_data,
  output logic                        o_rd_load,
  output reg_addr_t                   o_rd_reg,
  lq_store_if.store                   store
);

  logic [LQ_DEPTH-1:0] tag_vld;
  logic [LQ_DEPTH-1:0] data_vld;
  logic [LQ_DEPTH-1:0] set_tag;
  logic [LQ_DEPTH-1:0] clr_entry;
  logic [LQ_DEPTH-1:0] set_data;

  logic      tag_load  [LQ_DEPTH];
  reg_addr_t tag_rd    [LQ_DEPTH];
  ld_size_t  meta_size [LQ_DEPTH];
  byte_off_t meta_off  [LQ_DEPTH];
  word_t     data_q    [LQ_DEPTH];

  // per-entry set and clear strobes
  always_comb begin
    for (int e = 0; e < LQ_DEPTH; e++) begin
      set_tag[e]   = i_alloc && (i_wr_idx == e);
      clr_entry[e] = i_rden && (i_rd_idx == e);
      set_data[e]  = i_ex_vld && (i_ex_id == e);  // metadata writes leave data valid alone
      for (int p = 0; p < NUM_RET_PORTS; p++) begin
        if (store.wr_en[p] && (store.wr_id[p] == e)) begin
          set_data[e] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      tag_vld  <= '0;
      data_vld <= '0;
    end else begin
      for (int e = 0; e < LQ_DEPTH; e++) begin
        if (clr_entry[e]) begin  // dequeue beats any set
          tag_vld[e]  <= 1'b0;
          data_vld[e] <= 1'b0;
        end else if (set_tag[e]) begin
          tag_vld[e]  <= 1'b1;
          data_vld[e] <= 1'b0;   // new entry waits for its result
        end else if (set_data[e]) begin
          data_vld[e] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_alloc) begin
      tag_load[i_wr_idx] <= i_alloc_load;
      tag_rd[i_wr_idx]   <= i_alloc_rd;
    end
    if (i_meta_vld) begin
      meta_size[i_meta_id] <= i_meta_size;
      meta_off[i_meta_id]  <= i_meta_offset;
    end
    if (i_ex_vld) begin
      data_q[i_ex_id] <= i_ex_data;
    end
    for (int p = 0; p < NUM_RET_PORTS; p++) begin
      if (store.wr_en[p]) begin
        data_q[store.wr_id[p]] <= store.wr_data[p];
      end
    end
  end

  // metadata for the return aligners
  always_comb begin
    for (int p = 0; p < NUM_RET_PORTS; p++) begin
      store.lookup_size[p]   = meta_size[store.lookup_id[p]];
      store.lookup_offset[p] = meta_off[store.lookup_id[p]];
    end
  end

  assign store.head_id       = i_rd_idx;
  assign store.head_size     = meta_size[i_rd_idx];
  assign store.head_offset   = meta_off[i_rd_idx];
  assign store.head_data     = data_q[i_rd_idx];
  assign store.head_data_vld = data_vld[i_rd_idx];
  assign store.head_is_load  = tag_load[i_rd_idx];

  assign o_rd_load = tag_load[i_rd_idx];
  assign o_rd_reg  = tag_rd[i_rd_idx];

  a_meta_alloc: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_meta_vld |-> tag_vld[i_meta_id])
    else $error("metadata write to free entry %0d", i_meta_id);

  a_ex_alloc: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ex_vld |-> tag_vld[i_ex_id])
    else $error("execute write to free entry %0d", i_ex_id);

  for (genvar p = 0; p < NUM_RET_PORTS; p++) begin : g_ret_chk
    // a memory return may only land on a live load entry
    a_ret_alloc: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      store.wr_en[p] |-> tag_vld[store.wr_id[p]] && tag_load[store.wr_id[p]])
      else $error("return port %0d writes entry %0d that holds no load", p, store.wr_id[p]);

    for (genvar q = p + 1; q < NUM_RET_PORTS; q++) begin : g_pair
      a_ret_distinct: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        store.wr_en[p] && store.wr_en[q] |-> store.wr_id[p] != store.wr_id[q])
        else $error("return ports %0d and %0d write the same entry", p, q);
    end
  end

endmodule

// ==== hw/lq_load_align.sv ====
// only the size codes of lq_pkg are defined; any other code passes the word through unchanged
module lq_load_align import lq_pkg::*; (
  input  word_t     i_word,
  input  ld_size_t  i_size,
  input  byte_off_t i_offset,
  output word_t     o_data
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  assign byte_sel = i_word[{i_offset, 3'b000} +: 8];
  assign half_sel = i_offset[1] ? i_word[31:16] : i_word[15:0];  // low offset bit ignored for halves

  always_comb begin
    case (i_size)
      SZ_B: begin
        o_data = {{24{byte_sel[7]}}, byte_sel};
      end
      SZ_H: begin
        o_data = {{16{half_sel[15]}}, half_sel};
      end
      SZ_BU: begin
        o_data = {24'h0, byte_sel};
      end
      SZ_HU: begin
        o_data = {16'h0, half_sel};
      end
      SZ_HNAN: begin
        o_data = {16'hffff, half_sel};  // fp16 boxed into a single
      end
      default: begin
        o_data = i_word;  // SZ_W
      end
    endcase
  end

endmodule

// ==== hw/lq_return_path.sv ====
// purely combinational; a bypassed return is not stored, and any cancel in the cycle kills o_fwd_vld
module lq_return_path import lq_pkg::*; #(
  parameter int LQ_DEPTH      = 8,
  parameter int NUM_RET_PORTS = 2
) (
  input  logic                                           i_bypass_disable,
  input  logic      [NUM_RET_PORTS-1:0]                  i_ret_vld,
  input  logic      [NUM_RET_PORTS-1:0]                  i_ret_cancel,
  input  logic [NUM_RET_PORTS-1:0][$clog2(LQ_DEPTH)-1:0] i_ret_id,
  input  word_t     [NUM_RET_PORTS-1:0]                  i_ret_data,
  output word_t                                          o_rd_data,
  output logic                                           o_data_ready,
  output logic                                           o_fwd_vld,
  output word_t                                          o_fwd_data,
  lq_store_if.ret                                        st
);

  logic [NUM_RET_PORTS-1:0] fwd_en;   // return hits the head, cancel not yet applied
  logic [NUM_RET_PORTS-1:0] byp_en;
  word_t                    aligned [NUM_RET_PORTS];
  word_t                    byp_word;
  word_t                    fwd_word;

  always_comb begin
    for (int p = 0; p < NUM_RET_PORTS; p++) begin
      fwd_en[p] = i_ret_vld[p] && st.head_is_load && (i_ret_id[p] == st.head_id);
      byp_en[p] = fwd_en[p] && !i_ret_cancel[p] && !i_bypass_disable;

      st.lookup_id[p] = i_ret_id[p];
      st.wr_id[p]     = i_ret_id[p];
      st.wr_en[p]     = i_ret_vld[p] && !i_ret_cancel[p] && !byp_en[p];
    end
  end

  // size and offset come back from the store for the returned entry
  for (genvar p = 0; p < NUM_RET_PORTS; p++) begin : g_align
    lq_load_align u_align (
      .i_word   (i_ret_data[p]),
      .i_size   (st.lookup_size[p]),
      .i_offset (st.lookup_offset[p]),
      .o_data   (aligned[p])
    );
  end

  // and-or muxes, at most one port hits the head in a legal cycle
  always_comb begin
    byp_word = '0;
    fwd_word = '0;
    for (int p = 0; p < NUM_RET_PORTS; p++) begin
      st.wr_data[p] = aligned[p];
      if (byp_en[p]) begin
        byp_word = byp_word | aligned[p];
      end
      if (fwd_en[p]) begin
        fwd_word = fwd_word | aligned[p];
      end
    end
  end

  assign o_data_ready = st.head_data_vld || (|byp_en);
  assign o_rd_data    = (|byp_en) ? byp_word : st.head_data;

  // cancel arrives late, so it gates the strobe after the hit detect
  assign o_fwd_vld  = (|fwd_en) && !(|i_ret_cancel);
  assign o_fwd_data = fwd_word;

endmodule

// ==== hw/lq_top.sv ====
// no back-pressure: the environment must honour o_full and o_data_ready, and LQ_DEPTH must be a power of two
module lq_top import lq_pkg::*; #(
  parameter int LQ_DEPTH      = 8,
  parameter int NUM_RET_PORTS = 2
) (
  input  logic                                           i_clk,
  input  logic                                           i_reset_n,
  input  logic                                           i_bypass_disable,
  // decode allocation
  input  logic                                           i_alloc,
  input  logic                                           i_alloc_load,
  input  reg_addr_t                                      i_alloc_rd,
  output logic [$clog2(LQ_DEPTH)-1:0]                    o_next_id,
  output logic                                           o_full,
  output logic                                           o_empty,
  // address stage
  input  logic                                           i_meta_vld,
  input  logic [$clog2(LQ_DEPTH)-1:0]                    i_meta_id,
  input  ld_size_t                                       i_meta_size,
  input  byte_off_t                                      i_meta_offset,
  // execute results
  input  logic                                           i_ex_vld,
  input  logic [$clog2(LQ_DEPTH)-1:0]                    i_ex_id,
  input  word_t                                          i_ex_data,
  // memory returns
  input  logic      [NUM_RET_PORTS-1:0]                  i_ret_vld,
  input  logic      [NUM_RET_PORTS-1:0]                  i_ret_cancel,
  input  logic [NUM_RET_PORTS-1:0][$clog2(LQ_DEPTH)-1:0] i_ret_id,
  input  word_t     [NUM_RET_PORTS-1:0]                  i_ret_data,
  // head read
  input  logic                                           i_rden,
  output logic [$clog2(LQ_DEPTH)-1:0]                    o_rd_id,
  output logic                                           o_rd_load,
  output reg_addr_t                                      o_rd_reg,
  output word_t                                          o_rd_data,
  output logic                                           o_data_ready,
  // register file forward
  output logic                                           o_fwd_vld,
  output logic [$clog2(LQ_DEPTH)-1:0]                    o_fwd_id,
  output word_t                                          o_fwd_data
);

  localparam int ID_W = $clog2(LQ_DEPTH);

  logic [ID_W-1:0] wr_idx;
  logic [ID_W-1:0] rd_idx;

  lq_store_if #(
    .LQ_DEPTH      (LQ_DEPTH),
    .NUM_RET_PORTS (NUM_RET_PORTS)
  ) store_bus ();

  lq_pointers #(
    .LQ_DEPTH (LQ_DEPTH)
  ) u_pointers (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_alloc   (i_alloc),
    .i_rden    (i_rden),
    .o_wr_idx  (wr_idx),
    .o_rd_idx  (rd_idx),
    .o_full    (o_full),
    .o_empty   (o_empty)
  );

  lq_entry_store #(
    .LQ_DEPTH      (LQ_DEPTH),
    .NUM_RET_PORTS (NUM_RET_PORTS)
  ) u_entry_store (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_alloc       (i_alloc),
    .i_wr_idx      (wr_idx),
    .i_alloc_load  (i_alloc_load),
    .i_alloc_rd    (i_alloc_rd),
    .i_rden        (i_rden),
    .i_rd_idx      (rd_idx),
    .i_meta_vld    (i_meta_vld),
    .i_meta_id     (i_meta_id),
    .i_meta_size   (i_meta_size),
    .i_meta_offset (i_meta_offset),
    .i_ex_vld      (i_ex_vld),
    .i_ex_id       (i_ex_id),
    .i_ex_data     (i_ex_data),
    .o_rd_load     (o_rd_load),
    .o_rd_reg      (o_rd_reg),
    .store         (store_bus.store)
  );

  lq_return_path #(
    .LQ_DEPTH      (LQ_DEPTH),
    .NUM_RET_PORTS (NUM_RET_PORTS)
  ) u_return_path (
    .i_bypass_disable (i_bypass_disable),
    .i_ret_vld        (i_ret_vld),
    .i_ret_cancel     (i_ret_cancel),
    .i_ret_id         (i_ret_id),
    .i_ret_data       (i_ret_data),
    .o_rd_data        (o_rd_data),
    .o_data_ready     (o_data_ready),
    .o_fwd_vld        (o_fwd_vld),
    .o_fwd_data       (o_fwd_data),
    .st               (store_bus.ret)
  );

  assign o_next_id = wr_idx;
  assign o_rd_id   = rd_idx;
  assign o_fwd_id  = rd_idx;  // forwards only ever come from the head

endmodule

// ==== tests/lq_tb.sv ====
// default parameters only (8 entries, 2 return ports); legal stimulus only, checks are assertions
module lq_tb import lq_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int LQ_DEPTH       = 8;
  localparam int NUM_RET_PORTS  = 2;
  localparam int RAND_CYCLES    = 900;
  localparam int TIMEOUT_CYCLES = 2000;  // tests take about 1000 cycles
  localparam int FIND_META      = 0;
  localparam int FIND_EX        = 1;
  localparam int FIND_RET       = 2;

  logic i_clk, i_reset_n, i_bypass_disable, i_alloc, i_alloc_load, i_rden;
  reg_addr_t i_alloc_rd;
  logic i_meta_vld, i_ex_vld;
  logic [2:0] i_meta_id, i_ex_id;
  ld_size_t i_meta_size;
  byte_off_t i_meta_offset;
  word_t i_ex_data;
  logic [NUM_RET_PORTS-1:0] i_ret_vld, i_ret_cancel;
  logic [NUM_RET_PORTS-1:0][2:0] i_ret_id;
  word_t [NUM_RET_PORTS-1:0] i_ret_data;
  logic [2:0] o_next_id, o_rd_id, o_fwd_id;
  logic o_full, o_empty, o_rd_load, o_data_ready, o_fwd_vld;
  reg_addr_t o_rd_reg;
  word_t o_rd_data, o_fwd_data;

  // reference model of the queue
  bit m_tag_vld [LQ_DEPTH];
  bit m_dvld [LQ_DEPTH];
  bit m_meta [LQ_DEPTH];
  bit m_load [LQ_DEPTH];
  reg_addr_t m_reg [LQ_DEPTH];
  ld_size_t m_size [LQ_DEPTH];
  byte_off_t m_off [LQ_DEPTH];
  word_t m_data [LQ_DEPTH];
  logic [2:0] m_wr, m_rd;
  int m_count;

  // expected outputs for the cycle being driven
  bit exp_ready, exp_fwd_vld, exp_rd_load;
  word_t exp_rd_data, exp_fwd_data;
  reg_addr_t exp_rd_reg;
  bit run_chk;
  int mismatch_count, other_count, cycle_count;
  ld_size_t sizes [6] = '{SZ_B, SZ_H, SZ_W, SZ_BU, SZ_HU, SZ_HNAN};

  lq_top lq_top_inst (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] got_v);
    mismatch_count++;
    $display("MISMATCH %s expected %h got %h at %0t", name, exp_v, got_v, $time);
  endtask

  a_full: assert property (@(posedge i_clk) disable iff (!run_chk)
    o_full == (m_count == LQ_DEPTH)) else report_mismatch("o_full", m_count == LQ_DEPTH,
    $sampled(o_full));
  a_empty: assert property (@(posedge i_clk) disable iff (!run_chk)
    o_empty == (m_count == 0)) else report_mismatch("o_empty", m_count == 0, $sampled(o_empty));
  a_next_id: assert property (@(posedge i_clk) disable iff (!run_chk)
    o_next_id == m_wr) else report_mismatch("o_next_id", m_wr, $sampled(o_next_id));
  a_rd_id: assert property (@(posedge i_clk) disable iff (!run_chk)
    o_rd_id == m_rd) else report_mismatch("o_rd_id", m_rd, $sampled(o_rd_id));
  a_ready: assert property (@(posedge i_clk) disable iff (!run_chk)
    o_data_ready == exp_ready) else report_mismatch("o_data_ready", exp_ready,
    $sampled(o_data_ready));
  a_rd_data: assert property (@(posedge i_clk) disable iff (!run_chk)
    exp_ready |-> o_rd_data == exp_rd_data)
    else report_mismatch("o_rd_data", exp_rd_data, $sampled(o_rd_data));
  a_fwd_vld: assert property (@(posedge i_clk) disable iff (!run_chk)
    o_fwd_vld == exp_fwd_vld) else report_mismatch("o_fwd_vld", exp_fwd_vld,
    $sampled(o_fwd_vld));
  a_fwd_data: assert property (@(posedge i_clk) disable iff (!run_chk)
    exp_fwd_vld |-> o_fwd_data == exp_fwd_data)
    else report_mismatch("o_fwd_data", exp_fwd_data, $sampled(o_fwd_data));
  a_fwd_id: assert property (@(posedge i_clk) disable iff (!run_chk)
    exp_fwd_vld |-> o_fwd_id == m_rd)
    else report_mismatch("o_fwd_id", m_rd, $sampled(o_fwd_id));
  a_rd_load: assert property (@(posedge i_clk) disable iff (!run_chk)
    i_rden |-> o_rd_load == exp_rd_load)
    else report_mismatch("o_rd_load", exp_rd_load, $sampled(o_rd_load));
  a_rd_reg: assert property (@(posedge i_clk) disable iff (!run_chk)
    i_rden |-> o_rd_reg == exp_rd_reg)
    else report_mismatch("o_rd_reg", exp_rd_reg, $sampled(o_rd_reg));

  // load result as the size and offset rules define it
  function automatic word_t expect_load(input word_t w, input ld_size_t sz, input byte_off_t off);
    logic [7:0]  b;
    logic [15:0] h;
    b = w >> (8 * off);
    h = w >> (16 * off[1]);  // halves ignore the low offset bit
    case (sz)
      SZ_B:    return 32'($signed(b));
      SZ_H:    return 32'($signed(h));
      SZ_BU:   return 32'(b);
      SZ_HU:   return 32'(h);
      SZ_HNAN: return {16'hffff, h};
      default: return w;
    endcase
  endfunction

  function automatic void set_expect();
    bit hit;
    bit byp;
    bit canc;
    word_t w;
    hit = 1'b0;
    byp = 1'b0;
    canc = 1'b0;
    exp_fwd_data = '0;
    exp_rd_data = m_data[m_rd];
    for (int p = 0; p < NUM_RET_PORTS; p++) begin
      canc |= i_ret_cancel[p];
      if (i_ret_vld[p] && i_ret_id[p] == m_rd && m_tag_vld[m_rd] && m_load[m_rd]) begin
        w = expect_load(i_ret_data[p], m_size[m_rd], m_off[m_rd]);
        hit = 1'b1;
        exp_fwd_data = w;
        if (!i_ret_cancel[p] && !i_bypass_disable) begin
          byp = 1'b1;
          exp_rd_data = w;  // bypass wins over the stored word
        end
      end
    end
    exp_ready = m_dvld[m_rd] || byp;
    exp_fwd_vld = hit && !canc;
    exp_rd_load = m_load[m_rd];
    exp_rd_reg = m_reg[m_rd];
  endfunction

  task automatic update_model();
    bit byp;
    for (int p = 0; p < NUM_RET_PORTS; p++) begin
      if (i_ret_vld[p] && !i_ret_cancel[p]) begin
        byp = i_ret_id[p] == m_rd && m_load[m_rd] && !i_bypass_disable;
        if (!byp) begin
          m_data[i_ret_id[p]] = expect_load(i_ret_data[p], m_size[i_ret_id[p]],
                                            m_off[i_ret_id[p]]);
          m_dvld[i_ret_id[p]] = 1'b1;
        end
      end
    end
    if (i_ex_vld) begin
      m_data[i_ex_id] = i_ex_data;
      m_dvld[i_ex_id] = 1'b1;
    end
    if (i_meta_vld) begin
      m_size[i_meta_id] = i_meta_size;
      m_off[i_meta_id] = i_meta_offset;
      m_meta[i_meta_id] = 1'b1;
    end
    if (i_alloc) begin
      m_tag_vld[m_wr] = 1'b1;
      m_dvld[m_wr] = 1'b0;
      m_meta[m_wr] = 1'b0;
      m_load[m_wr] = i_alloc_load;
      m_reg[m_wr] = i_alloc_rd;
      m_wr++;
      m_count++;
    end
    if (i_rden) begin  // dequeue clears last
      m_tag_vld[m_rd] = 1'b0;
      m_dvld[m_rd] = 1'b0;
      m_rd++;
      m_count--;
    end
  endtask

  task automatic clear_inputs();
    i_alloc = 1'b0;
    i_alloc_load = 1'b0;
    i_alloc_rd = '0;
    i_rden = 1'b0;
    i_meta_vld = 1'b0;
    i_meta_id = '0;
    i_meta_size = SZ_W;
    i_meta_offset = '0;
    i_ex_vld = 1'b0;
    i_ex_id = '0;
    i_ex_data = '0;
    i_ret_vld = '0;
    i_ret_cancel = '0;
    i_ret_id = '0;
    i_ret_data = '0;
  endtask

  // inputs held across one rising edge, then the model catches up
  task automatic tick();
    set_expect();
    @(negedge i_clk);
    update_model();
    clear_inputs();
  endtask

  task automatic alloc_entry(input bit is_load);
    i_alloc = 1'b1;
    i_alloc_load = is_load;
    i_alloc_rd = $urandom;
    tick();
  endtask

  task automatic write_meta(input logic [2:0] id, input ld_size_t sz, input byte_off_t off);
    i_meta_vld = 1'b1;
    i_meta_id = id;
    i_meta_size = sz;
    i_meta_offset = off;
    tick();
  endtask

  task automatic drive_return(input int port, input logic [2:0] id, input bit cancel);
    i_ret_vld[port] = 1'b1;
    i_ret_cancel[port] = cancel;
    i_ret_id[port] = id;
    i_ret_data[port] = $urandom;
  endtask

  task automatic dequeue();
    i_rden = 1'b1;
    tick();
  endtask

  function automatic bit find_entry(input int kind, input int skip, output logic [2:0] id);
    int start;
    int e;
    bit want;
    start = $urandom % LQ_DEPTH;
    id = '0;
    for (int k = 0; k < LQ_DEPTH; k++) begin
      e = (start + k) % LQ_DEPTH;
      case (kind)
        FIND_META: want = m_load[e] && !m_meta[e];
        FIND_EX:   want = !m_load[e] && !m_dvld[e];
        default:   want = m_load[e] && m_meta[e] && !m_dvld[e];
      endcase
      if (m_tag_vld[e] && want && e != skip) begin
        id = e[2:0];
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic random_step(input bit allow_alloc);
    logic [2:0] id_m, id_x, id0, id1;
    bit got_m, got_x, got0, got1;
    i_bypass_disable = ($urandom % 4 == 0);
    if (allow_alloc && m_count < LQ_DEPTH && $urandom % 2 == 0) begin
      i_alloc = 1'b1;
      i_alloc_load = ($urandom % 3 != 0);
      i_alloc_rd = $urandom;
    end
    got_m = find_entry(FIND_META, -1, id_m);
    if (got_m && $urandom % 2 == 0) begin
      i_meta_vld = 1'b1;
      i_meta_id = id_m;
      i_meta_size = sizes[$urandom % 6];
      i_meta_offset = $urandom;
    end
    got_x = find_entry(FIND_EX, -1, id_x);
    if (got_x && $urandom % 2 == 0) begin
      i_ex_vld = 1'b1;
      i_ex_id = id_x;
      i_ex_data = $urandom;
    end
    got0 = find_entry(FIND_RET, -1, id0);
    if (got0 && $urandom % 2 == 0) begin
      drive_return(0, id0, $urandom % 4 == 0);
    end
    got1 = find_entry(FIND_RET, i_ret_vld[0] ? int'(id0) : -1, id1);  // ports stay distinct
    if (got1 && $urandom % 2 == 0) begin
      drive_return(1, id1, $urandom % 4 == 0);
    end
    set_expect();
    if (exp_ready && $urandom % 3 != 0) begin
      i_rden = 1'b1;
    end
    tick();
  endtask

  task automatic end_run();
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  initial begin
    logic [2:0] base;
    void'($urandom(45));
    clear_inputs();
    i_bypass_disable = 1'b0;
    i_reset_n = 1'b0;
    m_wr = '0;
    m_rd = '0;
    m_count = 0;
    run_chk = 1'b0;
    repeat (8) @(negedge i_clk);
    i_reset_n = 1'b1;
    run_chk = 1'b1;
    tick();  // idle state after reset

    // fill to full, execute results, then drain
    for (int i = 0; i < LQ_DEPTH; i++) alloc_entry(1'b0);
    for (int i = 0; i < LQ_DEPTH; i++) begin
      i_ex_vld = 1'b1;
      i_ex_id = m_rd + i;
      i_ex_data = $urandom;
      tick();
    end
    for (int i = 0; i < LQ_DEPTH; i++) dequeue();

    // every size with every offset, returns to non-head entries first
    for (int s = 0; s < 6; s++) begin
      base = m_wr;
      for (int k = 0; k < 4; k++) alloc_entry(1'b1);
      for (int k = 0; k < 4; k++) write_meta(base + k, sizes[s], k);
      i_bypass_disable = 1'b0;
      for (int k = 1; k < 4; k++) begin
        drive_return(k % 2, base + k, 1'b0);
        tick();
      end
      i_bypass_disable = 1'b1;
      drive_return(0, base, 1'b0);
      tick();
      for (int k = 0; k < 4; k++) dequeue();
    end

    // bypass to the head, dequeued in the same cycle
    i_bypass_disable = 1'b0;
    alloc_entry(1'b1);
    write_meta(m_rd, SZ_HU, 2'd2);
    drive_return(1, m_rd, 1'b0);
    i_rden = 1'b1;
    tick();

    // cancels at the head and beside a forward
    base = m_wr;
    for (int k = 0; k < 3; k++) alloc_entry(1'b1);
    for (int k = 0; k < 3; k++) write_meta(base + k, SZ_B, k);
    drive_return(0, base, 1'b1);
    drive_return(1, base + 1, 1'b0);
    tick();
    tick();
    tick();
    i_bypass_disable = 1'b1;
    drive_return(1, base, 1'b0);
    drive_return(0, base + 2, 1'b1);  // kills the forward strobe
    tick();
    dequeue();
    dequeue();
    i_bypass_disable = 1'b0;
    drive_return(0, base + 2, 1'b0);
    i_rden = 1'b1;
    tick();

    for (int i = 0; i < RAND_CYCLES; i++) random_step(1'b1);
    while (m_count > 0) random_step(1'b0);
    tick();
    end_run();
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge i_clk);
      cycle_count++;
    end
    other_count++;
    $display("timeout after %0d cycles, the test sequence did not finish", cycle_count);
    end_run();
  end

endmodule

// ==== sources.f ====
hw/lq_pkg.sv
hw/lq_store_if.sv
hw/lq_pointers.sv
hw/lq_entry_store.sv
hw/lq_load_align.sv
hw/lq_return_path.sv
hw/lq_top.sv
tests/lq_tb.sv
